// File: Bender.yml
package:
  name: lampfpu

sources:
  - include_dirs:
      - common
    files:
      - common/lampfpu_pkg.sv
      - common/lampfpu_op_if.sv
      - arith/lampfpu_addsub.sv
      - arith/lampfpu_mul.sv
      - arith/lampfpu_cmp.sv
      - verilog/lampfpu_unpack.sv
      - verilog/lampfpu_ctrl.sv
      - verilog/lampfpu_round.sv
      - verilog/lampfpu_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - sim/tb_lampfpu.sv

// File: arith/lampfpu_addsub.sv
// two-stage bfloat16 adder and subtractor
// stage 1 aligns and adds, stage 2 normalizes
// exact zero is +0 in both modes, except (-0)+(-0)

`timescale 1ns/1ns
`include "lampfpu_defines.svh"

module lampfpu_addsub
	import lampfpu_pkg::*;
(
	input	logic				clk,
	input	logic				rst,
	input	logic				start_i,
	input	logic				sub_i,
	lampfpu_op_if.consumer		ops,
	output	prernd_t			res_o
);

	localparam int SIG_W = `LAMPFPU_F_DW + 1 + `LAMPFPU_GRS_DW;

	unpacked_t						big;
	unpacked_t						smaller;
	logic							b_sign;
	logic							big_sign;
	logic							eff_sub;
	logic	[2*SIG_W-1:0]			shifted;
	logic	[SIG_W-1:0]				aligned;
	logic	[SIG_W:0]				sum;
	logic							sum_sign;
	logic							sum_nan;
	logic							sum_inf;
	logic							s1_valid;
	logic							s1_sign;
	logic							s1_nan;
	logic							s1_inf;
	logic	[`LAMPFPU_E_DW-1:0]		s1_exp;
	logic	[SIG_W:0]				s1_sum;
	logic	[3:0]					lz;
	logic	[SIG_W-1:0]				norm_sig;
	logic signed	[`LAMPFPU_E_DW+1:0]	norm_exp;

	function automatic logic [3:0] lead_zeros(input logic [SIG_W-1:0] v);
		logic	[3:0]	n;
		logic			found;
		n = 4'(SIG_W);
		found = 1'b0;
		for (int i = SIG_W - 1; i >= 0; i--)
		begin
			if (v[i] && !found)
			begin
				n = 4'(SIG_W - 1 - i);
				found = 1'b1;
			end
		end
		return n;
	endfunction

	//////////////////////////////////////////////////
	// stage 1 alignment and significand add
	//////////////////////////////////////////////////

	always_comb
	begin
		b_sign		= ops.op_b.sign ^ sub_i;
		big			= ops.a_ge_b ? ops.op_a : ops.op_b;
		smaller		= ops.a_ge_b ? ops.op_b : ops.op_a;
		big_sign	= ops.a_ge_b ? ops.op_a.sign : b_sign;
		eff_sub		= ops.op_a.sign ^ b_sign;
		shifted		= {smaller.sig, {`LAMPFPU_GRS_DW{1'b0}}, {SIG_W{1'b0}}} >> ops.e_diff;
		aligned		= shifted[2*SIG_W-1 -: SIG_W];
		// jam everything shifted out into the sticky bit
		if (ops.e_diff >= SIG_W)
			aligned[0] = aligned[0] | (|smaller.sig);
		else
			aligned[0] = aligned[0] | (|shifted[SIG_W-1:0]);
		if (eff_sub)
			sum = {1'b0, big.sig, {`LAMPFPU_GRS_DW{1'b0}}} - {1'b0, aligned};
		else
			sum = {1'b0, big.sig, {`LAMPFPU_GRS_DW{1'b0}}} + {1'b0, aligned};
		sum_nan = ops.op_a.is_nan || ops.op_b.is_nan ||
			(ops.op_a.is_inf && ops.op_b.is_inf && eff_sub);
		sum_inf = ops.op_a.is_inf || ops.op_b.is_inf;
		if (ops.op_a.is_inf)
			sum_sign = ops.op_a.sign;
		else if (ops.op_b.is_inf)
			sum_sign = b_sign;
		else if (sum == '0)
			sum_sign = ops.op_a.sign & b_sign;
		else
			sum_sign = big_sign;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			s1_valid <= 1'b0;
		else
			s1_valid <= start_i;
		if (start_i)
		begin
			s1_sign	<= sum_sign;
			s1_exp	<= big.exp;
			s1_sum	<= sum;
			s1_nan	<= sum_nan;
			s1_inf	<= sum_inf;
		end
	end

	//////////////////////////////////////////////////
	// stage 2 normalization
	//////////////////////////////////////////////////

	assign lz = lead_zeros(s1_sum[SIG_W-1:0]);

	always_comb
	begin
		if (s1_sum[SIG_W])
		begin
			// carry out, one step right keeping the sticky
			norm_sig = {s1_sum[SIG_W:2], |s1_sum[1:0]};
			norm_exp = $signed({2'b00, s1_exp}) + 10'sd1;
		end
		else
		begin
			norm_sig = s1_sum[SIG_W-1:0] << lz;
			norm_exp = $signed({2'b00, s1_exp}) - $signed({6'b0, lz});
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			res_o.valid <= 1'b0;
		else
			res_o.valid <= s1_valid;
		if (s1_valid)
		begin
			res_o.sign		<= s1_sign;
			res_o.exp		<= norm_exp;
			res_o.sig		<= norm_sig;
			res_o.is_nan	<= s1_nan;
			res_o.is_inf	<= s1_inf && !s1_nan;
			res_o.is_zero	<= (s1_sum == '0) && !s1_nan && !s1_inf;
		end
	end

endmodule

// File: arith/lampfpu_cmp.sv
// one-stage EQ/LT/LE comparator
// cmp_op_i is 01 for EQ, 10 for LT, 11 for LE and 00 for none
// any NaN gives 0, +0 equals -0

`timescale 1ns/1ns
`include "lampfpu_defines.svh"

module lampfpu_cmp
	import lampfpu_pkg::*;
(
	input	logic				clk,
	input	logic				rst,
	input	logic	[1:0]		cmp_op_i,
	lampfpu_op_if.consumer		ops,
	output	prernd_t			res_o
);

	logic	any_nan;
	logic	both_zero;
	logic	mag_eq;
	logic	is_eq;
	logic	is_lt;
	logic	cmp_bit;

	always_comb
	begin
		any_nan		= ops.op_a.is_nan || ops.op_b.is_nan;
		both_zero	= ops.op_a.is_zero && ops.op_b.is_zero;
		mag_eq		= {ops.op_a.exp, ops.op_a.sig} == {ops.op_b.exp, ops.op_b.sig};
		is_eq		= both_zero || (ops.op_a.sign == ops.op_b.sign && mag_eq);
		if (both_zero)
			is_lt = 1'b0;
		else if (ops.op_a.sign != ops.op_b.sign)
			is_lt = ops.op_a.sign;
		// both negative, order flips
		else if (ops.op_a.sign)
			is_lt = ops.a_ge_b && !mag_eq;
		else
			is_lt = !ops.a_ge_b;
		case (cmp_op_i)
			2'b01:		cmp_bit = is_eq;
			2'b10:		cmp_bit = is_lt;
			2'b11:		cmp_bit = is_lt || is_eq;
			default:	cmp_bit = 1'b0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			res_o.valid <= 1'b0;
		else
			res_o.valid <= |cmp_op_i;
		if (|cmp_op_i)
		begin
			res_o.sign		<= 1'b0;
			res_o.exp		<= '0;
			// result bit sits in the lsb of the significand
			res_o.sig		<= {{(`LAMPFPU_F_DW+`LAMPFPU_GRS_DW){1'b0}}, cmp_bit && !any_nan};
			res_o.is_nan	<= 1'b0;
			res_o.is_inf	<= 1'b0;
			res_o.is_zero	<= 1'b0;
		end
	end

endmodule

// File: arith/lampfpu_mul.sv
// two-stage bfloat16 multiplier
// stage 1 forms the 16-bit product, stage 2 normalizes it
// zero times infinity gives NaN

`timescale 1ns/1ns
`include "lampfpu_defines.svh"

module lampfpu_mul
	import lampfpu_pkg::*;
(
	input	logic				clk,
	input	logic				rst,
	input	logic				start_i,
	lampfpu_op_if.consumer		ops,
	output	prernd_t			res_o
);

	localparam int SIG_W = `LAMPFPU_F_DW + 1 + `LAMPFPU_GRS_DW;
	localparam int PW = 2 * (`LAMPFPU_F_DW + 1);

	logic							s1_valid;
	logic							s1_sign;
	logic signed	[`LAMPFPU_E_DW+1:0]	s1_exp;
	logic	[PW-1:0]				s1_prod;
	logic							s1_nan;
	logic							s1_inf;
	logic							s1_zero;

	always_ff @(posedge clk)
	begin
		if (rst)
			s1_valid <= 1'b0;
		else
			s1_valid <= start_i;
		if (start_i)
		begin
			s1_sign	<= ops.op_a.sign ^ ops.op_b.sign;
			s1_prod	<= ops.op_a.sig * ops.op_b.sig;
			s1_exp	<= $signed({2'b00, ops.op_a.exp}) + $signed({2'b00, ops.op_b.exp}) -
				`LAMPFPU_BIAS;
			s1_nan	<= ops.op_a.is_nan || ops.op_b.is_nan ||
				(ops.op_a.is_zero && ops.op_b.is_inf) ||
				(ops.op_a.is_inf && ops.op_b.is_zero);
			s1_inf	<= ops.op_a.is_inf || ops.op_b.is_inf;
			s1_zero	<= ops.op_a.is_zero || ops.op_b.is_zero;
		end
	end

	// product is 1.x or 1x.x, the top bit decides the shift
	always_ff @(posedge clk)
	begin
		if (rst)
			res_o.valid <= 1'b0;
		else
			res_o.valid <= s1_valid;
		if (s1_valid)
		begin
			if (s1_prod[PW-1])
			begin
				res_o.sig	<= {s1_prod[PW-1 -: SIG_W-1], |s1_prod[PW-SIG_W:0]};
				res_o.exp	<= s1_exp + 10'sd1;
			end
			else
			begin
				res_o.sig	<= {s1_prod[PW-2 -: SIG_W-1], |s1_prod[PW-SIG_W-1:0]};
				res_o.exp	<= s1_exp;
			end
			res_o.sign		<= s1_sign;
			res_o.is_nan	<= s1_nan;
			res_o.is_inf	<= s1_inf && !s1_nan;
			res_o.is_zero	<= s1_zero && !s1_nan;
		end
	end

endmodule

// File: common/lampfpu_defines.svh
// field widths and constants of the bfloat16 unit
// the word is 1 sign, 8 exponent and 7 fraction bits
// subnormals are not supported anywhere in the datapath

`ifndef LAMPFPU_DEFINES_SVH
`define LAMPFPU_DEFINES_SVH

`define LAMPFPU_DW		16
`define LAMPFPU_E_DW	8
`define LAMPFPU_F_DW	7

// guard, round and sticky below the fraction
`define LAMPFPU_GRS_DW	3

`define LAMPFPU_BIAS	127
`define LAMPFPU_QNAN	16'h7FC0

`endif

// File: common/lampfpu_op_if.sv
// unpacked operand pair from the unpacker to the units
// no handshake, the unpacker refreshes the pair every cycle
// units must capture what they need on their start pulse

`timescale 1ns/1ns
`include "lampfpu_defines.svh"

interface lampfpu_op_if
	import lampfpu_pkg::*;
();

	unpacked_t						op_a;
	unpacked_t						op_b;
	// |a| >= |b|
	logic							a_ge_b;
	logic	[`LAMPFPU_E_DW-1:0]		e_diff;

	modport producer
	(
		output	op_a,
		output	op_b,
		output	a_ge_b,
		output	e_diff
	);

	modport consumer
	(
		input	op_a,
		input	op_b,
		input	a_ge_b,
		input	e_diff
	);

endinterface

// File: common/lampfpu_pkg.sv
// shared types of the bfloat16 unit
// operands arrive unpacked with the hidden bit already attached
// unit results leave unrounded with three extra low bits

`include "lampfpu_defines.svh"

package lampfpu_pkg;

	typedef enum logic [2:0]
	{
		IDLE	= 3'd0,
		ADD		= 3'd1,
		SUB		= 3'd2,
		MUL		= 3'd3,
		EQ		= 3'd4,
		LT		= 3'd5,
		LE		= 3'd6
	} opcode_t;

	typedef enum logic
	{
		RNE		= 1'b0,
		RTZ		= 1'b1
	} rnd_mode_t;

	// one operand after classification
	typedef struct packed
	{
		logic								sign;
		logic	[`LAMPFPU_E_DW-1:0]			exp;
		logic	[`LAMPFPU_F_DW:0]			sig;
		logic								is_zero;
		logic								is_inf;
		logic								is_nan;
	} unpacked_t;

	// unit result before rounding
	// sig holds hidden bit, fraction, then guard/round/sticky
	typedef struct packed
	{
		logic											valid;
		logic											sign;
		logic signed	[`LAMPFPU_E_DW+1:0]				exp;
		logic	[`LAMPFPU_F_DW+`LAMPFPU_GRS_DW:0]		sig;
		logic											is_nan;
		logic											is_inf;
		logic											is_zero;
	} prernd_t;

endpackage

// File: sim/tb_lampfpu.sv
// testbench for the bfloat16 unit
// operands come from $random with a fixed seed
// the model works on exact wide integers, then rounds by mode
// subnormal inputs and tiny results are flushed to signed zero
// the run stops at the first mismatch

`timescale 1ns/1ns
`include "lampfpu_defines.svh"

module tb_lampfpu
	import lampfpu_pkg::*;
();

	// wide enough for any aligned pair of significands
	localparam int MW = 288;
	localparam int MAX_OPS = 400;
	localparam int CYCLES_PER_OP = 8;
	localparam int CYCLE_LIMIT = MAX_OPS * CYCLES_PER_OP + 100;
	localparam int VALID_WAIT = 16;

	logic						clk;
	logic						rst;
	logic						flush_i;
	logic						padv_i;
	opcode_t					opcode_i;
	rnd_mode_t					rnd_mode_i;
	logic	[`LAMPFPU_DW-1:0]	op1_i;
	logic	[`LAMPFPU_DW-1:0]	op2_i;
	logic	[`LAMPFPU_DW-1:0]	result_o;
	logic						valid_o;
	logic						ready_o;

	integer						seed;
	int							cycles;
	logic	[`LAMPFPU_DW-1:0]	specials [0:11];

	lampfpu_top UUT
	(
		.clk			(clk),
		.rst			(rst),
		.flush_i		(flush_i),
		.padv_i			(padv_i),
		.opcode_i		(opcode_i),
		.rnd_mode_i		(rnd_mode_i),
		.op1_i			(op1_i),
		.op2_i			(op2_i),
		.result_o		(result_o),
		.valid_o		(valid_o),
		.ready_o		(ready_o)
	);

	always #20 clk = ~clk;

	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("error: run went past %0d cycles without finishing", CYCLE_LIMIT);
			$display("Test failed");
			$fatal(1);
		end
	end

	//////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////

	// value is mag * 2^(e0 - 134), mag nonzero
	function automatic logic [15:0] round_pack(input logic sign, input logic [MW-1:0] mag,
		input int e0, input rnd_mode_t mode);
		int					p;
		int					sh;
		int					e;
		logic	[MW-1:0]	kept;
		logic	[MW-1:0]	rem;
		logic	[MW-1:0]	half;
		logic	[MW-1:0]	one;
		logic	[15:0]		res;
		one = 1;
		p = 0;
		for (int i = 0; i < MW; i++)
		begin
			if (mag[i])
				p = i;
		end
		e = e0 + p - 7;
		if (p > 7)
		begin
			sh = p - 7;
			kept = mag >> sh;
			rem = mag & ((one << sh) - one);
			half = one << (sh - 1);
			if (mode == RNE && (rem > half || (rem == half && kept[0])))
				kept = kept + one;
		end
		else
			kept = mag << (7 - p);
		// rounding carried into a new leading bit
		if (kept[8])
		begin
			kept = kept >> 1;
			e = e + 1;
		end
		if (e < 1)
			res = {sign, 15'h0000};
		else if (e > 254)
			res = (mode == RTZ) ? {sign, 15'h7F7F} : {sign, 15'h7F80};
		else
			res = {sign, 8'(e), kept[6:0]};
		return res;
	endfunction

	function automatic logic [15:0] reference_result(input opcode_t op, input rnd_mode_t mode,
		input logic [15:0] a, input logic [15:0] b);
		logic				sa;
		logic				sb;
		logic				za;
		logic				zb;
		logic				ia;
		logic				ib;
		logic				na;
		logic				nb;
		int					xa;
		int					xb;
		int					emin;
		int					ka;
		int					kb;
		logic	[MW-1:0]	ma;
		logic	[MW-1:0]	mb;
		logic	[MW-1:0]	mag;
		logic				s;
		logic	[15:0]		res;
		sa = a[15];
		sb = b[15];
		xa = a[14:7];
		xb = b[14:7];
		za = (xa == 0);
		zb = (xb == 0);
		ia = (xa == 255) && (a[6:0] == 0);
		ib = (xb == 255) && (b[6:0] == 0);
		na = (xa == 255) && (a[6:0] != 0);
		nb = (xb == 255) && (b[6:0] != 0);
		ma = '0;
		mb = '0;
		if (!za)
			ma[7:0] = {1'b1, a[6:0]};
		if (!zb)
			mb[7:0] = {1'b1, b[6:0]};
		ka = za ? 0 : int'(a[14:0]);
		kb = zb ? 0 : int'(b[14:0]);
		if (sa)
			ka = -ka;
		if (sb)
			kb = -kb;
		res = '0;
		case (op)
			ADD, SUB:
			begin
				// x - y is x + (-y)
				if (op == SUB)
					sb = ~sb;
				if (na || nb || (ia && ib && sa != sb))
					res = `LAMPFPU_QNAN;
				else if (ia)
					res = {sa, 15'h7F80};
				else if (ib)
					res = {sb, 15'h7F80};
				else if (za && zb)
					res = {sa & sb, 15'h0000};
				else
				begin
					if (za)
						emin = xb;
					else if (zb || xa < xb)
						emin = xa;
					else
						emin = xb;
					ma = ma << (xa - emin);
					mb = mb << (xb - emin);
					if (sa == sb)
					begin
						mag = ma + mb;
						s = sa;
					end
					else if (ma >= mb)
					begin
						mag = ma - mb;
						s = sa;
					end
					else
					begin
						mag = mb - ma;
						s = sb;
					end
					// exact cancellation gives +0
					if (mag == '0)
						res = 16'h0000;
					else
						res = round_pack(s, mag, emin, mode);
				end
			end
			MUL:
			begin
				s = sa ^ sb;
				if (na || nb || (za && ib) || (ia && zb))
					res = `LAMPFPU_QNAN;
				else if (ia || ib)
					res = {s, 15'h7F80};
				else if (za || zb)
					res = {s, 15'h0000};
				else
					res = round_pack(s, ma * mb, xa + xb - 134, mode);
			end
			EQ:
				res = (!na && !nb && ka == kb) ? 16'h0001 : 16'h0000;
			LT:
				res = (!na && !nb && ka < kb) ? 16'h0001 : 16'h0000;
			LE:
				res = (!na && !nb && ka <= kb) ? 16'h0001 : 16'h0000;
			default:
				res = '0;
		endcase
		return res;
	endfunction

	//////////////////////////////////////////////////
	// stimulus helpers
	//////////////////////////////////////////////////

	function automatic int bounded_rand(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	function automatic logic [15:0] normal_operand();
		logic	[31:0]	r;
		r = $random(seed);
		return {r[15], 8'(1 + r[31:8] % 254), r[6:0]};
	endfunction

	// exponent within 8 of the reference value
	function automatic logic [15:0] nearby_operand(input logic [15:0] x);
		logic	[31:0]	r;
		int				e;
		r = $random(seed);
		e = int'(x[14:7]) + int'(r[11:8]) - 8;
		if (e < 1)
			e = 1;
		if (e > 254)
			e = 254;
		return {r[15], 8'(e), r[6:0]};
	endfunction

	function automatic rnd_mode_t random_mode();
		logic	[31:0]	r;
		r = $random(seed);
		return r[3] ? RTZ : RNE;
	endfunction

	task automatic check_value(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		if (expected !== actual)
		begin
			$display("error %s: expected %h, actual %h", name, expected, actual);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	task automatic wait_for_valid();
		int		n;
		n = 0;
		while (!valid_o && n < VALID_WAIT)
		begin
			@(negedge clk);
			n++;
		end
		if (!valid_o)
		begin
			$display("error: valid_o did not rise within %0d cycles", VALID_WAIT);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	// called on a falling edge with the controller idle
	task automatic issue_op(input string name, input opcode_t op, input rnd_mode_t mode,
		input logic [15:0] a, input logic [15:0] b);
		logic	[15:0]	expected;
		logic	[15:0]	held;
		int				hold;
		expected = reference_result(op, mode, a, b);
		flush_i = 1'b0;
		opcode_i = op;
		rnd_mode_i = mode;
		op1_i = a;
		op2_i = b;
		@(negedge clk);
		opcode_i = IDLE;
		wait_for_valid();
		check_value(name, expected, result_o);
		held = result_o;
		// back-pressure with an opcode waiting
		hold = bounded_rand(6);
		opcode_i = op;
		repeat (hold)
		begin
			@(negedge clk);
			check_value("hold valid", 16'h0001, valid_o);
			check_value("hold result", held, result_o);
			check_value("hold ready", 16'h0001, ready_o);
		end
		opcode_i = IDLE;
		padv_i = 1'b1;
		@(negedge clk);
		padv_i = 1'b0;
		check_value("release valid", 16'h0000, valid_o);
	endtask

	task automatic flush_then_run(input opcode_t op, input rnd_mode_t mode,
		input logic [15:0] a, input logic [15:0] b);
		int		n;
		n = 4 + bounded_rand(3);
		flush_i = 1'b1;
		opcode_i = op;
		rnd_mode_i = mode;
		op1_i = a;
		op2_i = b;
		repeat (n)
		begin
			@(negedge clk);
			check_value("flush valid", 16'h0000, valid_o);
		end
		issue_op("after flush", op, mode, a, b);
	endtask

	// signed zeros, subnormals, NaN and infinity against each compare
	task automatic compare_corners(input opcode_t op);
		issue_op("cmp zero", op, RNE, 16'h0000, 16'h8000);
		issue_op("cmp zero", op, RNE, 16'h8000, 16'h0000);
		issue_op("cmp subnormal", op, RNE, 16'h0001, 16'h8000);
		issue_op("cmp nan", op, RNE, 16'h7FC0, 16'h3F80);
		issue_op("cmp nan", op, RNE, 16'h3F80, 16'hFFC1);
		issue_op("cmp sign", op, RNE, 16'hBF80, 16'h3F80);
		issue_op("cmp sign", op, RNE, 16'h3F80, 16'hBF80);
		issue_op("cmp inf", op, RNE, 16'h7F80, 16'h7F80);
	endtask

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////

	initial
	begin
		logic	[15:0]	a;
		logic	[15:0]	b;
		opcode_t		op;
		seed = 50969;
		cycles = 0;
		clk = 1'b0;
		rst = 1'b1;
		flush_i = 1'b0;
		padv_i = 1'b0;
		opcode_i = IDLE;
		rnd_mode_i = RNE;
		op1_i = '0;
		op2_i = '0;
		specials[0] = 16'h0000;
		specials[1] = 16'h8000;
		specials[2] = 16'h7F80;
		specials[3] = 16'hFF80;
		specials[4] = 16'h7FC0;
		specials[5] = 16'hFFC1;
		specials[6] = 16'h0001;
		specials[7] = 16'h8040;
		specials[8] = 16'h3F80;
		specials[9] = 16'hBF80;
		specials[10] = 16'h7F7F;
		specials[11] = 16'h0080;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		check_value("reset valid", 16'h0000, valid_o);
		check_value("reset result", 16'h0000, result_o);
		check_value("reset ready", 16'h0001, ready_o);

		// add and subtract, half with close exponents for cancellation
		for (int i = 0; i < 100; i++)
		begin
			a = normal_operand();
			b = bounded_rand(2) ? nearby_operand(a) : normal_operand();
			op = bounded_rand(2) ? SUB : ADD;
			issue_op("addsub", op, random_mode(), a, b);
		end
		issue_op("add overflow", ADD, RNE, 16'h7F7F, 16'h7F7F);
		issue_op("add overflow", ADD, RTZ, 16'h7F7F, 16'h7F7F);

		// full exponent range reaches overflow and underflow
		for (int i = 0; i < 80; i++)
		begin
			if (bounded_rand(2))
			begin
				a = nearby_operand(16'h3F80);
				b = nearby_operand(16'h3F80);
			end
			else
			begin
				a = normal_operand();
				b = normal_operand();
			end
			issue_op("mul", MUL, random_mode(), a, b);
		end
		issue_op("mul overflow", MUL, RNE, 16'h7F7F, 16'h4000);
		issue_op("mul overflow", MUL, RTZ, 16'h7F7F, 16'h4000);
		issue_op("mul overflow", MUL, RTZ, 16'hFF7F, 16'h4000);
		issue_op("mul underflow", MUL, RNE, 16'h0080, 16'h3F00);
		issue_op("mul underflow", MUL, RNE, 16'h8080, 16'h3F00);

		for (int i = 0; i < 60; i++)
		begin
			a = normal_operand();
			case (bounded_rand(3))
				0:			b = a;
				1:			b = nearby_operand(a);
				default:	b = normal_operand();
			endcase
			op = opcode_t'(3'(EQ + bounded_rand(3)));
			issue_op("cmp", op, RNE, a, b);
		end
		compare_corners(EQ);
		compare_corners(LT);
		compare_corners(LE);

		for (int i = 0; i < 60; i++)
		begin
			a = specials[bounded_rand(12)];
			b = specials[bounded_rand(12)];
			op = opcode_t'(3'(1 + bounded_rand(6)));
			issue_op("special", op, random_mode(), a, b);
		end

		for (int i = 0; i < 10; i++)
		begin
			op = opcode_t'(3'(1 + bounded_rand(6)));
			flush_then_run(op, random_mode(), normal_operand(), normal_operand());
		end

		$display("Test completed successfully");
		$finish;
	end

endmodule

// File: src.f
+incdir+common
common/lampfpu_pkg.sv
common/lampfpu_op_if.sv
arith/lampfpu_addsub.sv
arith/lampfpu_mul.sv
arith/lampfpu_cmp.sv
verilog/lampfpu_unpack.sv
verilog/lampfpu_ctrl.sv
verilog/lampfpu_round.sv
verilog/lampfpu_top.sv
sim/tb_lampfpu.sv

// File: verilog/lampfpu_ctrl.sv
// idle/work/done controller of the unit
// flush_i only blocks acceptance, it does not abort work in flight
// ready_o is combinational on opcode_i

`timescale 1ns/1ns
`include "lampfpu_defines.svh"

module lampfpu_ctrl
	import lampfpu_pkg::*;
(
	input	logic						clk,
	input	logic						rst,
	input	logic						flush_i,
	input	logic						padv_i,
	input	opcode_t					opcode_i,
	input	rnd_mode_t					rnd_mode_i,
	input	logic						rnd_valid_i,
	input	logic	[`LAMPFPU_DW-1:0]	rnd_result_i,
	output	logic						add_start_o,
	output	logic						sub_o,
	output	logic						mul_start_o,
	output	logic	[1:0]				cmp_op_o,
	output	opcode_t					sel_o,
	output	rnd_mode_t					rnd_mode_o,
	output	logic	[`LAMPFPU_DW-1:0]	result_o,
	output	logic						valid_o,
	output	logic						ready_o
);

	typedef enum logic [1:0]
	{
		S_IDLE,
		S_WORK,
		S_DONE
	} state_t;

	state_t		state;
	logic		accept;

	assign accept = (state == S_IDLE) && (opcode_i != IDLE) && !flush_i;
	assign ready_o = (opcode_i == IDLE) || valid_o;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state		<= S_IDLE;
			add_start_o	<= 1'b0;
			sub_o		<= 1'b0;
			mul_start_o	<= 1'b0;
			cmp_op_o	<= 2'b00;
			sel_o		<= IDLE;
			rnd_mode_o	<= RNE;
			result_o	<= '0;
			valid_o		<= 1'b0;
		end
		else
		begin
			// start pulses last one cycle
			add_start_o	<= 1'b0;
			mul_start_o	<= 1'b0;
			cmp_op_o	<= 2'b00;
			case (state)
				S_IDLE:
				begin
					if (accept)
					begin
						state		<= S_WORK;
						sel_o		<= opcode_i;
						rnd_mode_o	<= rnd_mode_i;
						sub_o		<= (opcode_i == SUB);
						case (opcode_i)
							ADD, SUB:	add_start_o	<= 1'b1;
							MUL:		mul_start_o	<= 1'b1;
							EQ:			cmp_op_o	<= 2'b01;
							LT:			cmp_op_o	<= 2'b10;
							LE:			cmp_op_o	<= 2'b11;
							default:	;
						endcase
					end
				end
				S_WORK:
				begin
					if (rnd_valid_i)
					begin
						result_o	<= rnd_result_i;
						valid_o		<= 1'b1;
						state		<= S_DONE;
					end
				end
				default:
				begin
					if (padv_i)
					begin
						valid_o		<= 1'b0;
						sel_o		<= IDLE;
						state		<= S_IDLE;
					end
				end
			endcase
		end
	end

	// a single unit starts, and only right after acceptance
	assert property (@(posedge clk) disable iff (rst)
		(add_start_o || mul_start_o || (|cmp_op_o)) |->
			$onehot0({add_start_o, mul_start_o, |cmp_op_o}) &&
			state == S_WORK && $past(state) == S_IDLE);

	// held result under back-pressure
	assert property (@(posedge clk) disable iff (rst)
		(state == S_DONE && !padv_i) |=> $stable(valid_o) && $stable(result_o));

endmodule

// File: verilog/lampfpu_round.sv
// picks the active unit and rounds its result
// overflow saturates under RTZ, underflow flushes to signed zero
// compare results pass through as 0 or 1

`timescale 1ns/1ns
`include "lampfpu_defines.svh"

module lampfpu_round
	import lampfpu_pkg::*;
(
	input	opcode_t					sel_i,
	input	rnd_mode_t					rnd_mode_i,
	input	prernd_t					add_i,
	input	prernd_t					mul_i,
	input	prernd_t					cmp_i,
	output	logic	[`LAMPFPU_DW-1:0]	result_o,
	output	logic						valid_o
);

	prernd_t							r;
	logic								is_cmp;
	logic								inc;
	logic	[`LAMPFPU_F_DW+1:0]			rounded;
	logic signed	[`LAMPFPU_E_DW+1:0]	exp_r;

	always_comb
	begin
		case (sel_i)
			ADD, SUB:	r = add_i;
			MUL:		r = mul_i;
			EQ, LT, LE:	r = cmp_i;
			default:	r = '0;
		endcase
	end

	assign is_cmp = (sel_i == EQ) || (sel_i == LT) || (sel_i == LE);
	assign valid_o = r.valid;

	// nearest even, guard set and anything below it or an odd lsb
	assign inc = (rnd_mode_i == RNE) && r.sig[`LAMPFPU_GRS_DW-1] &&
		(r.sig[`LAMPFPU_GRS_DW-2] || r.sig[0] || r.sig[`LAMPFPU_GRS_DW]);
	assign rounded = {1'b0, r.sig[`LAMPFPU_F_DW+`LAMPFPU_GRS_DW:`LAMPFPU_GRS_DW]} +
		{{(`LAMPFPU_F_DW+1){1'b0}}, inc};
	// carry out means 10.0000000, fraction bits are already zero
	assign exp_r = $signed(r.exp) + $signed({{(`LAMPFPU_E_DW+1){1'b0}}, rounded[`LAMPFPU_F_DW+1]});

	//////////////////////////////////////////////////
	// packing with special values
	//////////////////////////////////////////////////

	always_comb
	begin
		if (is_cmp)
			result_o = {{(`LAMPFPU_DW-1){1'b0}}, r.sig[0]};
		else if (r.is_nan)
			result_o = `LAMPFPU_QNAN;
		else if (r.is_inf)
			result_o = {r.sign, {`LAMPFPU_E_DW{1'b1}}, {`LAMPFPU_F_DW{1'b0}}};
		else if (r.is_zero || exp_r < 10'sd1)
			result_o = {r.sign, {(`LAMPFPU_DW-1){1'b0}}};
		else if (exp_r > 10'sd254 && rnd_mode_i == RTZ)
			result_o = {r.sign, {(`LAMPFPU_E_DW-1){1'b1}}, 1'b0, {`LAMPFPU_F_DW{1'b1}}};
		else if (exp_r > 10'sd254)
			result_o = {r.sign, {`LAMPFPU_E_DW{1'b1}}, {`LAMPFPU_F_DW{1'b0}}};
		else
			result_o = {r.sign, exp_r[`LAMPFPU_E_DW-1:0], rounded[`LAMPFPU_F_DW-1:0]};
	end

	// units only report while the controller has an operation selected
	always_comb
	begin
		assert final ($isunknown(sel_i) || sel_i != IDLE ||
			!(add_i.valid || mul_i.valid || cmp_i.valid))
			else $error("unit result with no operation selected");
	end

endmodule

// File: verilog/lampfpu_top.sv
// bfloat16 unit with add, sub, mul and compare
// one operation at a time, latency depends on the opcode
// result is held until padv_i, subnormals are flushed to zero

`timescale 1ns/1ns
`include "lampfpu_defines.svh"

module lampfpu_top
	import lampfpu_pkg::*;
(
	input	logic						clk,
	input	logic						rst,
	input	logic						flush_i,
	input	logic						padv_i,
	input	opcode_t					opcode_i,
	input	rnd_mode_t					rnd_mode_i,
	input	logic	[`LAMPFPU_DW-1:0]	op1_i,
	input	logic	[`LAMPFPU_DW-1:0]	op2_i,
	output	logic	[`LAMPFPU_DW-1:0]	result_o,
	output	logic						valid_o,
	output	logic						ready_o
);

	logic						add_start;
	logic						sub;
	logic						mul_start;
	logic	[1:0]				cmp_op;
	opcode_t					sel;
	rnd_mode_t					rnd_mode;
	prernd_t					add_res;
	prernd_t					mul_res;
	prernd_t					cmp_res;
	logic	[`LAMPFPU_DW-1:0]	rnd_result;
	logic						rnd_valid;

	lampfpu_op_if ops ();

	lampfpu_unpack u_unpack
	(
		.clk			(clk),
		.rst			(rst),
		.op1_i			(op1_i),
		.op2_i			(op2_i),
		.ops			(ops.producer)
	);

	lampfpu_ctrl u_ctrl
	(
		.clk			(clk),
		.rst			(rst),
		.flush_i		(flush_i),
		.padv_i			(padv_i),
		.opcode_i		(opcode_i),
		.rnd_mode_i		(rnd_mode_i),
		.rnd_valid_i	(rnd_valid),
		.rnd_result_i	(rnd_result),
		.add_start_o	(add_start),
		.sub_o			(sub),
		.mul_start_o	(mul_start),
		.cmp_op_o		(cmp_op),
		.sel_o			(sel),
		.rnd_mode_o		(rnd_mode),
		.result_o		(result_o),
		.valid_o		(valid_o),
		.ready_o		(ready_o)
	);

	//////////////////////////////////////////////////
	// functional units
	//////////////////////////////////////////////////

	lampfpu_addsub u_addsub
	(
		.clk			(clk),
		.rst			(rst),
		.start_i		(add_start),
		.sub_i			(sub),
		.ops			(ops.consumer),
		.res_o			(add_res)
	);

	lampfpu_mul u_mul
	(
		.clk			(clk),
		.rst			(rst),
		.start_i		(mul_start),
		.ops			(ops.consumer),
		.res_o			(mul_res)
	);

	lampfpu_cmp u_cmp
	(
		.clk			(clk),
		.rst			(rst),
		.cmp_op_i		(cmp_op),
		.ops			(ops.consumer),
		.res_o			(cmp_res)
	);

	lampfpu_round u_round
	(
		.sel_i			(sel),
		.rnd_mode_i		(rnd_mode),
		.add_i			(add_res),
		.mul_i			(mul_res),
		.cmp_i			(cmp_res),
		.result_o		(rnd_result),
		.valid_o		(rnd_valid)
	);

endmodule

// File: verilog/lampfpu_unpack.sv
// splits and classifies both operands every cycle
// an exponent field of zero counts as zero, subnormal fractions are dropped
// the magnitude order compares exponent then significand

`timescale 1ns/1ns
`include "lampfpu_defines.svh"

module lampfpu_unpack
	import lampfpu_pkg::*;
(
	input	logic						clk,
	input	logic						rst,
	input	logic	[`LAMPFPU_DW-1:0]	op1_i,
	input	logic	[`LAMPFPU_DW-1:0]	op2_i,
	lampfpu_op_if.producer				ops
);

	unpacked_t	a;
	unpacked_t	b;
	logic		a_ge_b;

	function automatic unpacked_t split_word(input logic [`LAMPFPU_DW-1:0] w);
		unpacked_t	u;
		logic		exp_max;
		logic		frac_nz;
		u.sign		= w[`LAMPFPU_DW-1];
		u.exp		= w[`LAMPFPU_DW-2 -: `LAMPFPU_E_DW];
		exp_max		= &u.exp;
		frac_nz		= |w[`LAMPFPU_F_DW-1:0];
		u.is_zero	= (u.exp == '0);
		u.is_inf	= exp_max && !frac_nz;
		u.is_nan	= exp_max && frac_nz;
		// hidden bit, cleared for zero and subnormal patterns
		u.sig		= u.is_zero ? '0 : {1'b1, w[`LAMPFPU_F_DW-1:0]};
		return u;
	endfunction

	assign a = split_word(op1_i);
	assign b = split_word(op2_i);
	assign a_ge_b = {a.exp, a.sig} >= {b.exp, b.sig};

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			ops.op_a	<= '0;
			ops.op_b	<= '0;
			ops.a_ge_b	<= 1'b0;
			ops.e_diff	<= '0;
		end
		else
		begin
			ops.op_a	<= a;
			ops.op_b	<= b;
			ops.a_ge_b	<= a_ge_b;
			ops.e_diff	<= a_ge_b ? (a.exp - b.exp) : (b.exp - a.exp);
		end
	end

endmodule
